// ==== verilog.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/cpu_core.sv
tb/tb_cpu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cpu_core \
    -f verilog.f \
    -o sim_cpu_core

./obj_dir/sim_cpu_core > sim.log
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi

// ==== tb/tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu_core import cpu_pkg::*; ();

    localparam int NUM_INSTR   = 2000;
    localparam int WATCHDOG_NS = (NUM_INSTR * 8 + 100) * 10;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   instr_valid;
    instr_t                 instr_word;
    logic                   wb_ready;
    logic                   instr_ready;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_index;
    logic [`WORD_W-1:0]     wb_value;

    // reference model state
    logic [`WORD_W-1:0]     model_regs [`REG_COUNT];
    logic [`REG_ADDR_W-1:0] exp_index [$];
    logic [`WORD_W-1:0]     exp_value [$];
    int                     accept_count;
    int                     monitor_errors = 0;
    int                     seq_errors = 0;
    logic                   stall_prev;
    logic [`REG_ADDR_W-1:0] held_index;
    logic [`WORD_W-1:0]     held_value;

    cpu_core u_cpu_core (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .wb_ready    (wb_ready),
        .instr_ready (instr_ready),
        .wb_valid    (wb_valid),
        .wb_index    (wb_index),
        .wb_value    (wb_value)
    );

    always #5 clk = ~clk;

    task automatic model_accept(input instr_t w);
        logic [`WORD_W-1:0]     a;
        logic [`WORD_W-1:0]     b;
        logic [`WORD_W-1:0]     imm_s;
        logic [`WORD_W-1:0]     imm_z;
        logic [`WORD_W-1:0]     res;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   legal;
        a     = model_regs[w.i.rs];
        b     = model_regs[w.i.rt];
        imm_s = {{(`WORD_W-`IMM_W){w.i.imm[`IMM_W-1]}}, w.i.imm};
        imm_z = {{(`WORD_W-`IMM_W){1'b0}}, w.i.imm};
        res   = '0;
        legal = 1'b1;
        dest  = w.i.rt;
        if (w.r.opcode == `OP_SPECIAL) begin
            dest = w.r.rd;
            case (w.r.funct)
                `FN_ADD: res = a + b;
                `FN_SUB: res = a - b;
                `FN_AND: res = a & b;
                `FN_OR:  res = a | b;
                `FN_XOR: res = a ^ b;
                `FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: legal = 1'b0;
            endcase
        end else begin
            case (w.i.opcode)
                `OP_ADDI: res = a + imm_s;
                `OP_SLTI: res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
                `OP_ANDI: res = a & imm_z;
                `OP_ORI:  res = a | imm_z;
                `OP_XORI: res = a ^ imm_z;
                `OP_LUI:  res = {w.i.imm, {(`WORD_W-`IMM_W){1'b0}}};
                default:  legal = 1'b0;
            endcase
        end
        // records leave in order, so the array may run ahead of the DUT
        if (legal) begin
            if (dest != '0) begin
                model_regs[dest] = res;
            end
            exp_index.push_back(dest);
            exp_value.push_back(res);
        end
    endtask

    function automatic instr_t random_instr();
        instr_t              w;
        int                  kind;
        logic [`FUNCT_W-1:0] code;
        w      = $urandom;
        w.i.rs = `REG_ADDR_W'($urandom % 8);
        w.i.rt = `REG_ADDR_W'($urandom % 8);
        kind   = $urandom % 12;
        if (($urandom % 10) != 0) begin
            if (kind < 6) begin
                w.r.opcode = `OP_SPECIAL;
                w.r.rd     = `REG_ADDR_W'($urandom % 8);
                w.r.shamt  = '0;
                case (kind)
                    0:       w.r.funct = `FN_ADD;
                    1:       w.r.funct = `FN_SUB;
                    2:       w.r.funct = `FN_AND;
                    3:       w.r.funct = `FN_OR;
                    4:       w.r.funct = `FN_XOR;
                    default: w.r.funct = `FN_SLT;
                endcase
            end else begin
                case (kind)
                    6:       w.i.opcode = `OP_ADDI;
                    7:       w.i.opcode = `OP_SLTI;
                    8:       w.i.opcode = `OP_ANDI;
                    9:       w.i.opcode = `OP_ORI;
                    10:      w.i.opcode = `OP_XORI;
                    default: w.i.opcode = `OP_LUI;
                endcase
            end
        end else if (kind < 6) begin
            // R-type with an unknown function code
            w.r.opcode = `OP_SPECIAL;
            do code = `FUNCT_W'($urandom);
            while (code inside {`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT});
            w.r.funct = code;
        end else begin
            do code = `OPCODE_W'($urandom);
            while (code inside {`OP_SPECIAL, `OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI,
                                `OP_XORI, `OP_LUI});
            w.i.opcode = code;
        end
        return w;
    endfunction

    function automatic instr_t i_word(input logic [`OPCODE_W-1:0] op,
                                      input logic [`REG_ADDR_W-1:0] rs,
                                      input logic [`REG_ADDR_W-1:0] rt,
                                      input logic [`IMM_W-1:0] imm);
        instr_t w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    // handshakes use the values held just before the edge
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                model_regs[i] = '0;
            end
            accept_count = 0;
            stall_prev   = 1'b0;
        end else begin
            if (instr_valid && instr_ready) begin
                accept_count++;
                model_accept(instr_word);
            end
            if (stall_prev) begin
                assert (wb_valid) else begin
                    $display("wb_valid dropped at %0t while the record was stalled", $time);
                    monitor_errors++;
                end
                assert (wb_index == held_index) else begin
                    $display("mismatch at %0t: wb_index got %0d expected %0d (stalled)",
                             $time, wb_index, held_index);
                    monitor_errors++;
                end
                assert (wb_value == held_value) else begin
                    $display("mismatch at %0t: wb_value got %h expected %h (stalled)",
                             $time, wb_value, held_value);
                    monitor_errors++;
                end
            end
            if (wb_valid && wb_ready) begin
                assert (exp_index.size() != 0) else begin
                    $display("writeback record at %0t with no instruction pending", $time);
                    monitor_errors++;
                end
                if (exp_index.size() != 0) begin
                    assert (wb_index == exp_index[0]) else begin
                        $display("mismatch at %0t: wb_index got %0d expected %0d",
                                 $time, wb_index, exp_index[0]);
                        monitor_errors++;
                    end
                    assert (wb_value == exp_value[0]) else begin
                        $display("mismatch at %0t: wb_value got %h expected %h",
                                 $time, wb_value, exp_value[0]);
                        monitor_errors++;
                    end
                    void'(exp_index.pop_front());
                    void'(exp_value.pop_front());
                end
            end
            stall_prev = wb_valid && !wb_ready;
            held_index = wb_index;
            held_value = wb_value;
        end
    end

    task automatic wait_drained();
        @(negedge clk);
        while (exp_index.size() != 0 || wb_valid) begin
            @(negedge clk);
        end
    endtask

    // one instruction alone in the pipe, output never stalled
    task automatic check_latency(input instr_t w);
        int edges;
        wb_ready = 1'b1;
        wait_drained();
        instr_valid = 1'b1;
        instr_word  = w;
        @(negedge clk);
        instr_valid = 1'b0;
        edges       = 1;
        while (!wb_valid && edges < 10) begin
            @(negedge clk);
            edges++;
        end
        assert (edges == 3) else begin
            $display("mismatch at %0t: wb_valid latency got %0d expected 3", $time, edges);
            seq_errors++;
        end
    endtask

    task automatic run_random(input int count, input logic ready_high);
        int target;
        int generated;
        int last_count;
        target     = accept_count + count;
        generated  = 0;
        last_count = accept_count;
        while (accept_count < target) begin
            @(negedge clk);
            wb_ready = ready_high || (($urandom % 4) != 0);
            // a held word stays until it is taken
            if (!instr_valid || accept_count != last_count) begin
                if (generated < count && ($urandom % 4) != 0) begin
                    instr_valid = 1'b1;
                    instr_word  = random_instr();
                    generated++;
                    last_count = accept_count;
                end else begin
                    instr_valid = 1'b0;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(89));
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr_word  = '0;
        wb_ready    = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (!wb_valid && instr_ready) else begin
            $display("pipeline not idle after reset at %0t", $time);
            seq_errors++;
        end
        // r0 reads zero, so ori returns its immediate
        check_latency(i_word(`OP_ORI, 5'd0, 5'd1, 16'h1234));
        check_latency(i_word(`OP_LUI, 5'd0, 5'd2, 16'h8001));
        check_latency(i_word(`OP_SLTI, 5'd2, 5'd3, 16'h0001));
        run_random(NUM_INSTR / 2, 1'b0);
        run_random(NUM_INSTR / 2, 1'b1);
        wb_ready = 1'b1;
        wait_drained();
        $display("errors: monitor %0d, sequence %0d", monitor_errors, seq_errors);
        if (monitor_errors + seq_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_core import cpu_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   instr_valid,
    input  wire instr_t                 instr_word,
    input  wire logic                   wb_ready,
    output logic                        instr_ready,
    output logic                        wb_valid,
    output logic [`REG_ADDR_W-1:0]      wb_index,
    output logic [`WORD_W-1:0]          wb_value
);

    // decode to execute
    logic                   d_valid;
    alu_op_t                d_alu_op;
    logic [`REG_ADDR_W-1:0] d_rs;
    logic [`REG_ADDR_W-1:0] d_rt;
    logic [`REG_ADDR_W-1:0] d_dest;
    logic                   d_use_imm;
    logic [`WORD_W-1:0]     d_imm;
    logic                   e_ready;

    // execute to result
    logic                   e_valid;
    logic [`REG_ADDR_W-1:0] e_dest;
    logic [`WORD_W-1:0]     e_value;
    logic                   r_ready;

    // register reads
    logic [`REG_ADDR_W-1:0] rd_index_a;
    logic [`REG_ADDR_W-1:0] rd_index_b;
    logic [`WORD_W-1:0]     rd_value_a;
    logic [`WORD_W-1:0]     rd_value_b;

    decode_stage u_decode_stage (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .e_ready     (e_ready),
        .instr_ready (instr_ready),
        .d_valid     (d_valid),
        .d_alu_op    (d_alu_op),
        .d_rs        (d_rs),
        .d_rt        (d_rt),
        .d_dest      (d_dest),
        .d_use_imm   (d_use_imm),
        .d_imm       (d_imm)
    );

    execute_stage u_execute_stage (
        .clk        (clk),
        .reset      (reset),
        .d_valid    (d_valid),
        .d_alu_op   (d_alu_op),
        .d_rs       (d_rs),
        .d_rt       (d_rt),
        .d_dest     (d_dest),
        .d_use_imm  (d_use_imm),
        .d_imm      (d_imm),
        .r_ready    (r_ready),
        .rd_value_a (rd_value_a),
        .rd_value_b (rd_value_b),
        .e_ready    (e_ready),
        .rd_index_a (rd_index_a),
        .rd_index_b (rd_index_b),
        .e_valid    (e_valid),
        .e_dest     (e_dest),
        .e_value    (e_value)
    );

    result_stage u_result_stage (
        .clk        (clk),
        .reset      (reset),
        .e_valid    (e_valid),
        .e_dest     (e_dest),
        .e_value    (e_value),
        .rd_index_a (rd_index_a),
        .rd_index_b (rd_index_b),
        .wb_ready   (wb_ready),
        .r_ready    (r_ready),
        .rd_value_a (rd_value_a),
        .rd_value_b (rd_value_b),
        .wb_valid   (wb_valid),
        .wb_index   (wb_index),
        .wb_value   (wb_value)
    );

endmodule

`default_nettype wire

// ==== hw/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module result_stage (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   e_valid,
    input  wire logic [`REG_ADDR_W-1:0] e_dest,
    input  wire logic [`WORD_W-1:0]     e_value,
    input  wire logic [`REG_ADDR_W-1:0] rd_index_a,
    input  wire logic [`REG_ADDR_W-1:0] rd_index_b,
    input  wire logic                   wb_ready,
    output logic                        r_ready,
    output logic [`WORD_W-1:0]          rd_value_a,
    output logic [`WORD_W-1:0]          rd_value_b,
    output logic                        wb_valid,
    output logic [`REG_ADDR_W-1:0]      wb_index,
    output logic [`WORD_W-1:0]          wb_value
);

    logic [`WORD_W-1:0] regs [`REG_COUNT];
    logic               wb_take;
    logic               pend_a;
    logic               pend_b;

    assign r_ready = !wb_valid || wb_ready;
    assign wb_take = wb_valid && wb_ready;

    // pending record not yet in the file
    assign pend_a = wb_valid && (wb_index == rd_index_a) && (wb_index != '0);
    assign pend_b = wb_valid && (wb_index == rd_index_b) && (wb_index != '0);

    assign rd_value_a = pend_a ? wb_value : regs[rd_index_a];
    assign rd_value_b = pend_b ? wb_value : regs[rd_index_b];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_take && (wb_index != '0)) begin
            regs[wb_index] <= wb_value;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (r_ready) begin
            wb_valid <= e_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (r_ready && e_valid) begin
            wb_index <= e_dest;
            wb_value <= e_value;
        end
    end

    a_wb_hold: assert property (@(posedge clk) disable iff (reset)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_index) && $stable(wb_value));

    // both read ports, bypass included
    a_zero_reg: assert property (@(posedge clk) disable iff (reset)
        ((rd_index_a != '0) || (rd_value_a == '0)) &&
        ((rd_index_b != '0) || (rd_value_b == '0)));

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module execute_stage import cpu_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   d_valid,
    input  wire alu_op_t                d_alu_op,
    input  wire logic [`REG_ADDR_W-1:0] d_rs,
    input  wire logic [`REG_ADDR_W-1:0] d_rt,
    input  wire logic [`REG_ADDR_W-1:0] d_dest,
    input  wire logic                   d_use_imm,
    input  wire logic [`WORD_W-1:0]     d_imm,
    input  wire logic                   r_ready,
    input  wire logic [`WORD_W-1:0]     rd_value_a,
    input  wire logic [`WORD_W-1:0]     rd_value_b,
    output logic                        e_ready,
    output logic [`REG_ADDR_W-1:0]      rd_index_a,
    output logic [`REG_ADDR_W-1:0]      rd_index_b,
    output logic                        e_valid,
    output logic [`REG_ADDR_W-1:0]      e_dest,
    output logic [`WORD_W-1:0]          e_value
);

    logic               fwd_a;
    logic               fwd_b;
    logic [`WORD_W-1:0] op_a;
    logic [`WORD_W-1:0] reg_b;
    logic [`WORD_W-1:0] op_b;
    logic [`WORD_W-1:0] alu_result;

    assign e_ready    = !e_valid || r_ready;
    assign rd_index_a = d_rs;
    assign rd_index_b = d_rt;

    // own result is the youngest, wins over the result stage bypass
    assign fwd_a = e_valid && (e_dest == d_rs) && (d_rs != '0);
    assign fwd_b = e_valid && (e_dest == d_rt) && (d_rt != '0);

    assign op_a  = fwd_a ? e_value : rd_value_a;
    assign reg_b = fwd_b ? e_value : rd_value_b;
    assign op_b  = d_use_imm ? d_imm : reg_b;

    always_comb begin
        case (d_alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(`WORD_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            // immediate already shifted up in decode
            ALU_LUI: alu_result = op_b;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            e_valid <= 1'b0;
        end else if (e_ready) begin
            e_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (e_ready && d_valid) begin
            e_dest  <= d_dest;
            e_value <= alu_result;
        end
    end

    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        e_valid && !r_ready |=> e_valid && $stable(e_dest) && $stable(e_value));

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   instr_valid,
    input  wire instr_t                 instr_word,
    input  wire logic                   e_ready,
    output logic                        instr_ready,
    output logic                        d_valid,
    output alu_op_t                     d_alu_op,
    output logic [`REG_ADDR_W-1:0]      d_rs,
    output logic [`REG_ADDR_W-1:0]      d_rt,
    output logic [`REG_ADDR_W-1:0]      d_dest,
    output logic                        d_use_imm,
    output logic [`WORD_W-1:0]          d_imm
);

    logic                   dec_legal;
    alu_op_t                dec_alu_op;
    logic                   dec_use_imm;
    logic [`REG_ADDR_W-1:0] dec_rs;
    logic [`REG_ADDR_W-1:0] dec_rt;
    logic [`REG_ADDR_W-1:0] dec_dest;
    logic [`WORD_W-1:0]     dec_imm;
    logic [`WORD_W-1:0]     imm_sext;
    logic [`WORD_W-1:0]     imm_zext;
    logic [`WORD_W-1:0]     imm_upper;
    logic                   accept;

    assign instr_ready = !d_valid || e_ready;
    assign accept      = instr_valid && instr_ready;

    assign imm_sext  = {{(`WORD_W-`IMM_W){instr_word.i.imm[`IMM_W-1]}}, instr_word.i.imm};
    assign imm_zext  = {{(`WORD_W-`IMM_W){1'b0}}, instr_word.i.imm};
    assign imm_upper = {instr_word.i.imm, {(`WORD_W-`IMM_W){1'b0}}};

    always_comb begin
        // I-type view by default
        dec_legal   = 1'b1;
        dec_alu_op  = ALU_ADD;
        dec_use_imm = 1'b1;
        dec_rs      = instr_word.i.rs;
        dec_rt      = instr_word.i.rt;
        dec_dest    = instr_word.i.rt;
        dec_imm     = imm_sext;
        if (instr_word.r.opcode == `OP_SPECIAL) begin
            dec_use_imm = 1'b0;
            dec_dest    = instr_word.r.rd;
            case (instr_word.r.funct)
                `FN_ADD: dec_alu_op = ALU_ADD;
                `FN_SUB: dec_alu_op = ALU_SUB;
                `FN_AND: dec_alu_op = ALU_AND;
                `FN_OR:  dec_alu_op = ALU_OR;
                `FN_XOR: dec_alu_op = ALU_XOR;
                `FN_SLT: dec_alu_op = ALU_SLT;
                default: dec_legal  = 1'b0;
            endcase
        end else begin
            case (instr_word.i.opcode)
                `OP_ADDI: dec_alu_op = ALU_ADD;
                `OP_SLTI: dec_alu_op = ALU_SLT;
                `OP_ANDI: begin
                    dec_alu_op = ALU_AND;
                    dec_imm    = imm_zext;
                end
                `OP_ORI: begin
                    dec_alu_op = ALU_OR;
                    dec_imm    = imm_zext;
                end
                `OP_XORI: begin
                    dec_alu_op = ALU_XOR;
                    dec_imm    = imm_zext;
                end
                `OP_LUI: begin
                    dec_alu_op = ALU_LUI;
                    dec_imm    = imm_upper;
                end
                default: dec_legal = 1'b0;
            endcase
        end
    end

    // illegal words are taken but never become valid
    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
        end else if (instr_ready) begin
            d_valid <= accept && dec_legal;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            d_alu_op  <= dec_alu_op;
            d_use_imm <= dec_use_imm;
            d_rs      <= dec_rs;
            d_rt      <= dec_rt;
            d_dest    <= dec_dest;
            d_imm     <= dec_imm;
        end
    end

    a_dest_known: assert property (@(posedge clk) disable iff (reset)
        d_valid |-> !$isunknown(d_dest));

endmodule

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    // register-register layout
    typedef struct packed {
        logic [`OPCODE_W-1:0]   opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`SHAMT_W-1:0]    shamt;
        logic [`FUNCT_W-1:0]    funct;
    } r_fields_t;

    // register-immediate layout
    typedef struct packed {
        logic [`OPCODE_W-1:0]   opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`IMM_W-1:0]      imm;
    } i_fields_t;

    // one instruction word, two readings
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

endpackage

`default_nettype wire

// ==== hw/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// architectural widths
`define WORD_W     32
`define REG_ADDR_W 5
`define REG_COUNT  32
`define IMM_W      16
`define OPCODE_W   6
`define FUNCT_W    6
`define SHAMT_W    5

// supported opcodes
`define OP_SPECIAL 6'h00
`define OP_ADDI    6'h08
`define OP_SLTI    6'h0a
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f

// R-type function codes
`define FN_ADD     6'h20
`define FN_SUB     6'h22
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_SLT     6'h2a

`endif
